/* vlog.f */
pcs_rx_pkg.sv
am_detector.sv
sync_fifo.sv
clock_comp_rx.sv
rx_block_decoder.sv
pcs_rx_top.sv
tb_pcs_rx.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --timescale 1ns/1ps --top-module tb_pcs_rx \
    -f vlog.f -o sim_tb_pcs_rx

./obj_dir/sim_tb_pcs_rx > sim.log 2>&1 || true
cat sim.log

if grep -q "SOME TESTS FAILED" sim.log; then
    echo "Simulation reported a failure"
    exit 1
fi
echo "Simulation finished without failures"

/* tb_pcs_rx.sv */
module tb_pcs_rx;

    timeunit 1ns;
    timeprecision 1ps;

    import pcs_rx_pkg::*;

    localparam int AM_BLOCK_PERIOD = 4;
    localparam int N_LANES         = 2;
    localparam int PERIOD_BLOCKS   = AM_BLOCK_PERIOD * N_LANES;  // 8 strobes per period
    localparam int PIPE_DEPTH      = 3;                          // Input strobe to o_valid

    typedef enum logic [2:0] {K_DATA, K_IDLE, K_CTRL, K_MARKER, K_BAD} kind_e;

    // One stimulus row of the table
    typedef struct packed {
        kind_e      kind;
        logic [1:0] lane;                                   // Marker lane
        logic       valid;
        logic [2:0] test_id;
        pcs_block_t block;
    } row_t;

    // One predicted output word
    typedef struct packed {
        pcs_block_t   block;
        block_class_e blk_class;
        logic         error;
        rx_state_e    state;
        logic [2:0]   test_id;
    } expect_t;

    string test_names [6] = '{"reset_quiet", "idle_then_data", "marker_delete",
                             "idle_insert", "bad_header", "random_mix"};

    logic        i_clock;
    logic        i_arst_n;
    logic        i_valid;
    pcs_block_t  i_block;
    logic        o_valid;
    pcs_rx_out_t o_out;
    rx_state_e   o_state;

    row_t       table_rows [$];
    expect_t    expected [$];                           // Model output, popped per o_valid
    expect_t    got;
    int         table_strobes;
    int         error_count;
    int         cycle_count;
    int         cycle_limit;
    int         strobes_in;
    int         strobes_out;
    int         markers_seen;                           // Active lane markers at the output
    logic [2:0] valid_hist;                             // Past i_valid, oldest on top

    pcs_rx_top
    #(
        .AM_BLOCK_PERIOD (AM_BLOCK_PERIOD),
        .N_LANES         (N_LANES),
        .NB_ADDR         (5)
    )
    dut_i
    (
        .i_clock         (i_clock),
        .i_arst_n        (i_arst_n),
        .i_valid         (i_valid),
        .i_block         (i_block),
        .o_valid         (o_valid),
        .o_out           (o_out),
        .o_state         (o_state)
    );

    always #20 i_clock = ~i_clock;

    task automatic check_value(input string name, input logic [127:0] exp_val,
                               input logic [127:0] act_val);
        if (exp_val !== act_val)
        begin
            error_count++;
            $display("FAILED %s expected %0h actual %0h", name, exp_val, act_val);
            $display("SOME TESTS FAILED");
            $fatal(1, "Mismatch in %s", name);
        end
    endtask

    function automatic pcs_block_t make_block(input kind_e kind, input logic [1:0] lane);
        pcs_block_t blk;
        logic [7:0] btype;
        case (kind)
            K_DATA:   blk = {SH_DATA, $urandom(), $urandom()};
            K_IDLE:   blk = PCS_IDLE;
            K_MARKER: blk = AM_TABLE[lane];
            K_BAD:    blk = {{2{1'($urandom())}}, $urandom(), $urandom()};  // 00 or 11
            default:
            begin
                case (2'($urandom()))                   // Non-idle control types
                    2'd0:    btype = 8'h78;
                    2'd1:    btype = 8'h87;
                    2'd2:    btype = 8'h99;
                    default: btype = 8'hFF;
                endcase
                blk = {SH_CTRL, btype, 24'($urandom()), $urandom()};
            end
        endcase
        return blk;
    endfunction

    task automatic add_row(input kind_e kind, input int lane, input logic valid, input int test_id);
        row_t row;
        row.kind    = kind;
        row.lane    = 2'(lane);
        row.valid   = valid;
        row.test_id = 3'(test_id);
        row.block   = make_block(kind, 2'(lane));
        table_rows.push_back(row);
        if (valid)
            table_strobes++;
    endtask

    task automatic add_run(input kind_e kind, input int count, input logic valid, input int test_id);
        for (int i = 0; i < count; i++)
            add_row(kind, 0, valid, test_id);
    endtask

    task automatic build_table();
        int pick;
        add_run(K_IDLE, 4, 1'b0, 0);                    // Bus quiet after reset
        add_run(K_IDLE, 6, 1'b1, 1);
        add_run(K_DATA, 6, 1'b1, 1);
        add_row(K_DATA, 0, 1'b1, 2);
        add_row(K_MARKER, 0, 1'b1, 2);
        add_run(K_DATA, 3, 1'b1, 2);
        add_row(K_MARKER, 1, 1'b1, 2);
        add_row(K_MARKER, 2, 1'b1, 2);                  // Inactive lane, passes as control
        add_run(K_DATA, 2, 1'b1, 2);
        add_run(K_IDLE, 10, 1'b1, 3);                   // Long RX_C stretch spans a period start
        add_row(K_IDLE, 0, 1'b0, 3);
        add_run(K_DATA, 6, 1'b1, 3);
        add_run(K_IDLE, 4, 1'b1, 3);
        add_row(K_DATA, 0, 1'b1, 4);
        add_row(K_BAD, 0, 1'b1, 4);
        add_row(K_DATA, 0, 1'b1, 4);                    // Stays in RX_E
        add_row(K_IDLE, 0, 1'b1, 4);
        add_row(K_DATA, 0, 1'b1, 4);
        for (int i = 0; i < 48; i++)
        begin
            pick = $urandom() % 6;
            if ($urandom() % 8 == 0)
                add_row(K_DATA, 0, 1'b0, 5);            // Gap in the strobes
            else if (table_strobes % PERIOD_BLOCKS == 2)
                add_row(K_MARKER, 0, 1'b1, 5);
            else if (table_strobes % PERIOD_BLOCKS == 5)
                add_row(K_MARKER, 1, 1'b1, 5);
            else if (pick < 3)
                add_row(K_DATA, 0, 1'b1, 5);
            else if (pick < 5)
                add_row(K_IDLE, 0, 1'b1, 5);
            else
                add_row(K_CTRL, 0, 1'b1, 5);
        end
    endtask

    function automatic block_class_e classify(input pcs_block_t blk);
        if (blk.sh == SH_DATA)
            return CLASS_DATA;
        if (blk.sh != SH_CTRL)
            return CLASS_BAD;
        return (blk.payload[63:56] == 8'h1E) ? CLASS_IDLE : CLASS_CTRL;
    endfunction

    function automatic rx_state_e next_state_of(input rx_state_e state, input block_class_e cls);
        if (cls == CLASS_BAD)
            return RX_E;
        case (state)
            RX_INIT: return (cls == CLASS_DATA) ? RX_E : RX_C;
            RX_E:    return (cls == CLASS_IDLE) ? RX_C : RX_E;
            default: return (cls == CLASS_DATA) ? RX_D : RX_C;
        endcase
    endfunction

    // Cycle model of tag, compensate and decode, one table row per clock
    task automatic build_expected();
        logic         s1_valid;
        logic         s1_tag;
        pcs_block_t   s1_block;
        logic [2:0]   s1_id;
        logic         s2_valid;
        pcs_block_t   s2_block;
        logic [2:0]   s2_id;
        pcs_block_t   comp_block;
        pcs_block_t   fifo [$];
        rx_state_e    state;
        block_class_e cls;
        logic         insert;
        int           period_cnt;
        int           idle_cnt;
        row_t         row;
        expect_t      entry;
        s1_valid   = 1'b0;
        s1_tag     = 1'b0;
        s1_block   = '0;
        s1_id      = '0;
        s2_valid   = 1'b0;
        s2_block   = '0;
        s2_id      = '0;
        comp_block = '0;
        state      = RX_INIT;
        period_cnt = 0;
        idle_cnt   = 0;
        fifo.push_back(PCS_IDLE);                       // Preset slot
        for (int c = 0; c < table_rows.size() + PIPE_DEPTH; c++)
        begin
            if (s1_valid)                               // Sees the decoder state before update
            begin
                insert = (state == RX_C) && (idle_cnt < N_LANES);
                if (insert || fifo.size() == 0)
                    comp_block = PCS_IDLE;
                else
                    comp_block = fifo.pop_front();
                if (!s1_tag)
                    fifo.push_back(s1_block);           // Markers dropped here
                if (period_cnt == PERIOD_BLOCKS - 1)
                begin
                    period_cnt = 0;
                    idle_cnt   = 0;
                end
                else
                begin
                    period_cnt++;
                    if (insert)
                        idle_cnt++;
                end
            end
            if (s2_valid)
            begin
                cls             = classify(s2_block);
                state           = next_state_of(state, cls);
                entry.block     = s2_block;
                entry.blk_class = cls;
                entry.error     = (state == RX_E);
                entry.state     = state;
                entry.test_id   = s2_id;
                expected.push_back(entry);
            end
            s2_valid = s1_valid;
            if (s1_valid)
            begin
                s2_block = comp_block;
                s2_id    = s1_id;
            end
            row      = (c < table_rows.size()) ? table_rows[c] : '0;
            s1_valid = row.valid;
            if (row.valid)
            begin
                s1_block = row.block;
                s1_id    = row.test_id;
                s1_tag   = (row.kind == K_MARKER) && (int'(row.lane) < N_LANES);
            end
        end
    endtask

    // Output monitor, sampled mid-cycle
    always @(negedge i_clock)
    begin
        check_value("o_valid_latency", 128'(valid_hist[2]), 128'(o_valid));
        if (o_valid)
        begin
            if (expected.size() == 0)
            begin
                $display("DUT produced an output block that the model did not predict");
                $display("SOME TESTS FAILED");
                $fatal(1, "Unexpected output strobe");
            end
            got = expected.pop_front();
            strobes_out++;
            for (int l = 0; l < N_LANES; l++)
                if (o_out.block == AM_TABLE[l])
                    markers_seen++;
            check_value($sformatf("%s block", test_names[got.test_id]),
                        128'(got.block), 128'(o_out.block));
            check_value($sformatf("%s class", test_names[got.test_id]),
                        128'(got.blk_class), 128'(o_out.blk_class));
            check_value($sformatf("%s error", test_names[got.test_id]),
                        128'(got.error), 128'(o_out.error));
            check_value($sformatf("%s state", test_names[got.test_id]),
                        128'(got.state), 128'(o_state));
        end
        else if (strobes_out == 0)
            check_value("reset_quiet state", 128'(RX_INIT), 128'(o_state));
        valid_hist = {valid_hist[1:0], i_valid};
    end

    // Run limit from the table length
    always @(posedge i_clock)
    begin
        if (i_arst_n)
            cycle_count++;
        if (cycle_count > cycle_limit)
        begin
            $display("Timeout, the run did not finish within %0d cycles", cycle_limit);
            $display("SOME TESTS FAILED");
            $fatal(1, "Timeout");
        end
    end

    initial
    begin
        void'($urandom(32'hc684));
        i_clock       = 1'b0;
        i_arst_n      = 1'b0;
        i_valid       = 1'b0;
        i_block       = PCS_IDLE;
        valid_hist    = '0;
        table_strobes = 0;
        error_count   = 0;
        cycle_count   = 0;
        strobes_in    = 0;
        strobes_out   = 0;
        markers_seen  = 0;
        build_table();
        build_expected();
        cycle_limit = table_rows.size() + 20;
        repeat (3) @(posedge i_clock);
        #2;
        i_arst_n = 1'b1;
        foreach (table_rows[r])
        begin
            @(posedge i_clock);
            #2;
            i_valid = table_rows[r].valid;
            i_block = table_rows[r].block;
            if (table_rows[r].valid)
                strobes_in++;
        end
        @(posedge i_clock);
        #2;
        i_valid = 1'b0;
        while (expected.size() != 0)                    // Drain, timeout guards this
            @(negedge i_clock);
        repeat (PIPE_DEPTH + 1) @(negedge i_clock);
        check_value("strobe_count", 128'(strobes_in), 128'(strobes_out));
        check_value("markers_at_output", 128'(0), 128'(markers_seen));
        if (error_count == 0)
        begin
            $display("ALL TESTS PASSED");
            $finish;
        end
        else
        begin
            $display("SOME TESTS FAILED");
            $fatal(1, "Errors found");
        end
    end

endmodule

/* pcs_rx_top.sv */
module pcs_rx_top
#(
    parameter int AM_BLOCK_PERIOD = 16383,
    parameter int N_LANES         = 4,
    parameter int NB_ADDR         = 5
)
(
    input  logic                      i_clock,
    input  logic                      i_arst_n,
    input  logic                      i_valid,
    input  pcs_rx_pkg::pcs_block_t    i_block,
    output logic                      o_valid,
    output pcs_rx_pkg::pcs_rx_out_t   o_out,
    output pcs_rx_pkg::rx_state_e     o_state
);

    import pcs_rx_pkg::*;

    logic        det_valid;
    pcs_tagged_t det_tagged;
    logic        comp_valid;
    pcs_block_t  comp_block;
    logic        fsm_control;                           // Decoder feedback, high in RX_C

    // Marker tagging
    am_detector
    #(
        .N_LANES         (N_LANES)
    )
    u_am_detector
    (
        .i_clock         (i_clock),
        .i_arst_n        (i_arst_n),
        .i_valid         (i_valid),
        .i_block         (i_block),
        .o_valid         (det_valid),
        .o_tagged        (det_tagged)
    );

    // Marker deletion and idle insertion
    clock_comp_rx
    #(
        .AM_BLOCK_PERIOD (AM_BLOCK_PERIOD),
        .N_LANES         (N_LANES),
        .NB_ADDR         (NB_ADDR)
    )
    u_clock_comp_rx
    (
        .i_clock         (i_clock),
        .i_arst_n        (i_arst_n),
        .i_valid         (det_valid),
        .i_tagged        (det_tagged),
        .i_fsm_control   (fsm_control),
        .o_valid         (comp_valid),
        .o_block         (comp_block)
    );

    rx_block_decoder u_rx_block_decoder
    (
        .i_clock         (i_clock),
        .i_arst_n        (i_arst_n),
        .i_valid         (comp_valid),
        .i_block         (comp_block),
        .o_fsm_control   (fsm_control),
        .o_valid         (o_valid),
        .o_out           (o_out),
        .o_state         (o_state)
    );

endmodule

/* rx_block_decoder.sv */
module rx_block_decoder
(
    input  logic                      i_clock,
    input  logic                      i_arst_n,
    input  logic                      i_valid,
    input  pcs_rx_pkg::pcs_block_t    i_block,
    output logic                      o_fsm_control,
    output logic                      o_valid,
    output pcs_rx_pkg::pcs_rx_out_t   o_out,
    output pcs_rx_pkg::rx_state_e     o_state
);

    import pcs_rx_pkg::*;

    block_class_e blk_class;                            // Kind of the incoming block
    rx_state_e    state;
    rx_state_e    next_state;
    pcs_block_t   block_q;
    block_class_e class_q;
    logic         error_q;
    logic         valid_q;

    // Classify by header, then by block type
    always_comb
    begin
        case (i_block.sh)
            SH_DATA:
            begin
                blk_class = CLASS_DATA;
            end
            SH_CTRL:
            begin
                if (i_block.payload[NB_PAYLOAD-1 -: 8] == BTYPE_IDLE)
                begin
                    blk_class = CLASS_IDLE;
                end
                else
                begin
                    blk_class = CLASS_CTRL;
                end
            end
            default:
            begin
                blk_class = CLASS_BAD;              // 00 or 11 header
            end
        endcase
    end

    // Receive state machine
    always_comb
    begin
        next_state = state;
        if (blk_class == CLASS_BAD)
        begin
            next_state = RX_E;
        end
        else
        begin
            case (state)
                RX_INIT: next_state = (blk_class == CLASS_DATA) ? RX_E : RX_C;
                RX_C:    next_state = (blk_class == CLASS_DATA) ? RX_D : RX_C;
                RX_D:    next_state = (blk_class == CLASS_DATA) ? RX_D : RX_C;
                RX_E:    next_state = (blk_class == CLASS_IDLE) ? RX_C : RX_E;
                default: next_state = RX_INIT;
            endcase
        end
    end

    // State and output control, all moved on strobes
    always_ff @(posedge i_clock or negedge i_arst_n)
    begin
        if (!i_arst_n)
        begin
            state   <= RX_INIT;
            valid_q <= 1'b0;
            class_q <= CLASS_IDLE;
            error_q <= 1'b0;
        end
        else
        begin
            valid_q <= i_valid;
            if (i_valid)
            begin
                state   <= next_state;
                class_q <= blk_class;
                error_q <= (next_state == RX_E);    // Block decoded into error
            end
        end
    end

    // Block itself is payload
    always_ff @(posedge i_clock)
    begin
        if (i_valid)
        begin
            block_q <= i_block;
        end
    end

    assign o_fsm_control   = (state == RX_C);       // Lets the compensator insert idles
    assign o_valid         = valid_q;
    assign o_state         = state;
    assign o_out.block     = block_q;
    assign o_out.blk_class = class_q;
    assign o_out.error     = error_q;

endmodule

/* clock_comp_rx.sv */
module clock_comp_rx
#(
    parameter int AM_BLOCK_PERIOD = 16383,              // Blocks between markers on one lane
    parameter int N_LANES         = 4,
    parameter int NB_ADDR         = 5
)
(
    input  logic                      i_clock,
    input  logic                      i_arst_n,
    input  logic                      i_valid,
    input  pcs_rx_pkg::pcs_tagged_t   i_tagged,
    input  logic                      i_fsm_control,    // Decoder sits in RX_C
    output logic                      o_valid,
    output pcs_rx_pkg::pcs_block_t    o_block
);

    import pcs_rx_pkg::*;

    localparam int PERIOD_BLOCKS = AM_BLOCK_PERIOD * N_LANES;
    localparam int NB_PERIOD_CNT = $clog2(PERIOD_BLOCKS + 1);
    localparam int NB_IDLE_CNT   = $clog2(N_LANES + 1);

    logic [NB_PERIOD_CNT-1:0] period_counter;
    logic [NB_IDLE_CNT-1:0]   idle_counter;         // Idles inserted this period
    logic                     period_done;
    logic                     idle_insert;
    logic                     fifo_write_enable;
    logic                     fifo_read_enable;
    logic [NB_BLOCK-1:0]      fifo_data;
    logic                     valid_q;

    assign period_done = (period_counter == NB_PERIOD_CNT'(PERIOD_BLOCKS - 1));

    // One idle per deleted marker while the decoder waits for control
    assign idle_insert = i_fsm_control && (idle_counter < NB_IDLE_CNT'(N_LANES));

    assign fifo_write_enable = ~i_tagged.am_tag;        // Markers never enter the FIFO
    assign fifo_read_enable  = ~idle_insert;            // Skipped read yields the idle word

    // Period and idle counters advance on strobes only
    always_ff @(posedge i_clock or negedge i_arst_n)
    begin
        if (!i_arst_n)
        begin
            period_counter <= '0;
            idle_counter   <= '0;
        end
        else if (i_valid)
        begin
            if (period_done)
            begin
                period_counter <= '0;                   // Wrap starts a new idle budget
                idle_counter   <= '0;
            end
            else
            begin
                period_counter <= period_counter + 1'b1;
                if (idle_insert)
                begin
                    idle_counter <= idle_counter + 1'b1;
                end
            end
        end
    end

    // Strobe lines up with the FIFO read register
    always_ff @(posedge i_clock or negedge i_arst_n)
    begin
        if (!i_arst_n)
        begin
            valid_q <= 1'b0;
        end
        else
        begin
            valid_q <= i_valid;
        end
    end

    sync_fifo
    #(
        .NB_DATA            (NB_BLOCK),
        .NB_ADDR            (NB_ADDR),
        .WR_PTR_AFTER_RESET (1)
    )
    u_sync_fifo
    (
        .i_clock            (i_clock),
        .i_arst_n           (i_arst_n),
        .i_enable           (1'b1),
        .i_valid            (i_valid),
        .i_write_enb        (fifo_write_enable),
        .i_read_enb         (fifo_read_enable),
        .i_data             (i_tagged.block),
        .o_empty            (),
        .o_data             (fifo_data)
    );

    assign o_valid = valid_q;
    assign o_block = fifo_data;                         // PCS_IDLE on inserted and empty slots

endmodule

/* sync_fifo.sv */
module sync_fifo
#(
    parameter int NB_DATA            = 66,
    parameter int NB_ADDR            = 5,
    parameter int WR_PTR_AFTER_RESET = 1                // Preset idle entries ahead of read
)
(
    input  logic               i_clock,
    input  logic               i_arst_n,
    input  logic               i_enable,
    input  logic               i_valid,
    input  logic               i_write_enb,
    input  logic               i_read_enb,
    input  logic [NB_DATA-1:0] i_data,
    output logic               o_empty,
    output logic [NB_DATA-1:0] o_data
);

    import pcs_rx_pkg::*;

    localparam int                 DEPTH     = 2 ** NB_ADDR;
    localparam logic [NB_DATA-1:0] IDLE_WORD = NB_DATA'(PCS_IDLE);

    logic [NB_DATA-1:0] mem [DEPTH];
    logic [NB_ADDR:0]   wr_ptr;                         // Extra top bit tells full from empty
    logic [NB_ADDR:0]   rd_ptr;
    logic [NB_ADDR:0]   preset_left;                    // Preset entries not yet read
    logic [NB_DATA-1:0] data_q;
    logic               step;
    logic               do_write;
    logic               do_read;

    assign step     = i_enable & i_valid;
    assign o_empty  = (wr_ptr == rd_ptr);
    assign do_write = step & i_write_enb;
    assign do_read  = step & i_read_enb & ~o_empty;     // Empty read holds the pointer

    // Storage
    always_ff @(posedge i_clock)
    begin
        if (do_write)
        begin
            mem[wr_ptr[NB_ADDR-1:0]] <= i_data;
        end
    end

    // Pointers, write side starts over the preset slots
    always_ff @(posedge i_clock or negedge i_arst_n)
    begin
        if (!i_arst_n)
        begin
            wr_ptr      <= (NB_ADDR+1)'(WR_PTR_AFTER_RESET);
            rd_ptr      <= '0;
            preset_left <= (NB_ADDR+1)'(WR_PTR_AFTER_RESET);
        end
        else
        begin
            if (do_write)
            begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_read)
            begin
                rd_ptr <= rd_ptr + 1'b1;
                if (preset_left != '0)
                begin
                    preset_left <= preset_left - 1'b1;
                end
            end
        end
    end

    // Registered read word, idle for preset slots and empty reads
    always_ff @(posedge i_clock)
    begin
        if (step)
        begin
            if (do_read && (preset_left == '0))
            begin
                data_q <= mem[rd_ptr[NB_ADDR-1:0]];
            end
            else
            begin
                data_q <= IDLE_WORD;
            end
        end
    end

    assign o_data = data_q;

endmodule

/* am_detector.sv */
module am_detector
#(
    parameter int N_LANES = 4                           // Active lanes up to MAX_LANES
)
(
    input  logic                      i_clock,
    input  logic                      i_arst_n,
    input  logic                      i_valid,
    input  pcs_rx_pkg::pcs_block_t    i_block,
    output logic                      o_valid,
    output pcs_rx_pkg::pcs_tagged_t   o_tagged
);

    import pcs_rx_pkg::*;

    logic        am_match;                              // Block equals an active lane marker
    logic        valid_q;
    pcs_tagged_t tagged_q;

    // Compare against the first N_LANES table entries only
    // Table markers carry a control header, so a match implies SH_CTRL
    always_comb
    begin
        am_match = 1'b0;
        for (int lane = 0; lane < MAX_LANES; lane++)
        begin
            if ((lane < N_LANES) && (i_block == AM_TABLE[lane]))
            begin
                am_match = 1'b1;
            end
        end
    end

    // Strobe register
    always_ff @(posedge i_clock or negedge i_arst_n)
    begin
        if (!i_arst_n)
        begin
            valid_q <= 1'b0;
        end
        else
        begin
            valid_q <= i_valid;
        end
    end

    // Block and tag loaded only on a strobe
    always_ff @(posedge i_clock)
    begin
        if (i_valid)
        begin
            tagged_q.block  <= i_block;
            tagged_q.am_tag <= am_match;
        end
    end

    assign o_valid  = valid_q;
    assign o_tagged = tagged_q;

endmodule

/* pcs_rx_pkg.sv */
package pcs_rx_pkg;

    // Coded block geometry
    localparam int NB_BLOCK   = 66;
    localparam int NB_PAYLOAD = 64;
    localparam int NB_SH      = NB_BLOCK - NB_PAYLOAD;
    localparam int MAX_LANES  = 4;                      // Marker table size

    // Valid sync headers, 00 and 11 are invalid
    localparam logic [NB_SH-1:0] SH_DATA = 2'b01;
    localparam logic [NB_SH-1:0] SH_CTRL = 2'b10;

    localparam logic [7:0] BTYPE_IDLE = 8'h1E;          // All-control block type

    // Idle block, type 0x1E then eight 7-bit idle characters
    localparam logic [NB_BLOCK-1:0] PCS_IDLE = {SH_CTRL, BTYPE_IDLE, 56'h0};

    // Per-lane alignment markers
    // M0 M1 M2 BIP3 M4 M5 M6 BIP7, BIP bytes fixed here
    localparam logic [NB_BLOCK-1:0] AM_TABLE [MAX_LANES] = '{
        {SH_CTRL, 64'hC1_68_21_00_3E_97_DE_FF},         // Lane 0
        {SH_CTRL, 64'h9D_71_8E_00_62_8E_71_FF},         // Lane 1
        {SH_CTRL, 64'h59_4B_E8_00_A6_B4_17_FF},         // Lane 2
        {SH_CTRL, 64'h4D_95_7B_00_B2_6A_84_FF}          // Lane 3
    };

    // One coded block, header on top
    typedef struct packed {
        logic [NB_SH-1:0]      sh;
        logic [NB_PAYLOAD-1:0] payload;
    } pcs_block_t;

    // Block plus marker flag from the detector
    typedef struct packed {
        pcs_block_t block;
        logic       am_tag;
    } pcs_tagged_t;

    // Decoded block kind
    typedef enum logic [1:0] {
        CLASS_DATA = 2'd0,
        CLASS_IDLE = 2'd1,
        CLASS_CTRL = 2'd2,
        CLASS_BAD  = 2'd3
    } block_class_e;

    // Receive decoder states
    typedef enum logic [1:0] {
        RX_INIT = 2'd0,
        RX_C    = 2'd1,                                 // Waiting for control blocks
        RX_D    = 2'd2,                                 // Inside a data run
        RX_E    = 2'd3                                  // Error
    } rx_state_e;

    // Top-level output word
    typedef struct packed {
        pcs_block_t   block;
        block_class_e blk_class;
        logic         error;
    } pcs_rx_out_t;

endpackage
